// ==== Makefile ====
# Verilator build and run of the mixer testbench

VERILATOR ?= verilator
TOP       ?= mixer_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "RESULT: PASS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
source/mixer_pkg.sv
source/sine_lut.sv
source/mixer.sv
source/iq_collector.sv
source/mixer_top.sv
test/mixer_tb.sv
test/mixer_checker.sv

// ==== source/iq_collector.sv ====
// joins the interleaved sine/cosine stream into parallel I/Q pairs
// sine word waits in a register until its cosine partner arrives
// output pair held until the sink takes it

`timescale 1ns/1ps

module iq_collector
  import mixer_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic signed [DATA_W-1:0] data_i,
  input  logic                     valid_i,
  input  logic                     last_i,
  output logic                     ready_o,
  output logic signed [DATA_W-1:0] i_o,
  output logic signed [DATA_W-1:0] q_o,
  output logic                     valid_o,
  input  logic                     ready_i
);

  logic signed [DATA_W-1:0] sin_word;  // pending first half of a pair
  logic                     xfer;

  // room when empty or the pair leaves this cycle
  assign ready_o = !valid_o || ready_i;
  assign xfer    = valid_i && ready_o;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      sin_word <= '0;
      i_o      <= '0;
      q_o      <= '0;
      valid_o  <= 1'b0;
    end else begin
      if (xfer && !last_i) begin
        sin_word <= data_i;
      end
      if (xfer && last_i) begin
        i_o     <= sin_word;  // sine product is I
        q_o     <= data_i;    // cosine product is Q
        valid_o <= 1'b1;
      end else if (ready_i) begin
        valid_o <= 1'b0;
      end
    end
  end

endmodule

// ==== source/mixer.sv ====
// mixer FSM
// holds one input sample, multiplies it by sine and then cosine
// and sends both products out as an interleaved stream with last on cosine
// owns the phase accumulator and the sine table instance

`timescale 1ns/1ps

module mixer
  import mixer_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic signed [DATA_W-1:0] sample_i,
  input  logic                     sample_valid_i,
  input  logic                     ready_i,
  output logic                     idle_o,
  output logic signed [DATA_W-1:0] data_o,
  output logic                     valid_o,
  output logic                     last_o
);

  mixer_state_t state;
  mixer_state_t next_state;

  logic signed [DATA_W-1:0]   sample_reg;   // held input sample
  logic signed [DATA_W-1:0]   lut_sample;   // oscillator value
  logic signed [2*DATA_W-1:0] product;
  logic [PHASE_W-1:0]         phase_reg;
  logic [PHASE_W-1:0]         phase_eff;
  logic [LUT_ABITS-1:0]       lut_addr;
  logic                       accept;
  logic                       xfer;

  assign accept = (state == MIX_IDLE) && sample_valid_i;
  assign xfer   = valid_o && ready_i;
  assign idle_o = (state == MIX_IDLE);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= MIX_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      MIX_IDLE:     if (sample_valid_i) next_state = MIX_SIN_MULT;
      MIX_SIN_MULT: next_state = MIX_SIN_WAIT;
      MIX_SIN_WAIT: if (ready_i) next_state = MIX_COS_MULT;
      MIX_COS_MULT: next_state = MIX_COS_WAIT;
      MIX_COS_WAIT: if (ready_i) next_state = MIX_IDLE;
      default:      next_state = MIX_IDLE;
    endcase
  end

  // stream strobes follow the wait states exactly
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid_o <= 1'b0;
      last_o  <= 1'b0;
    end else begin
      valid_o <= (next_state == MIX_SIN_WAIT) || (next_state == MIX_COS_WAIT);
      last_o  <= (next_state == MIX_COS_WAIT);
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      sample_reg <= '0;
    end else if (accept) begin
      sample_reg <= sample_i;
    end
  end

  // full-width product, scaled back by the table's fraction bits
  assign product = sample_reg * lut_sample;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      data_o <= '0;
    end else if ((state == MIX_SIN_MULT) || (state == MIX_COS_MULT)) begin
      data_o <= product[LUT_QBITS +: DATA_W];  // same bits as >>> LUT_QBITS
    end
  end

  // advance once the cosine word has gone
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      phase_reg <= '0;
    end else if ((state == MIX_COS_WAIT) && xfer) begin
      phase_reg <= phase_reg + PHASE_INC;  // wraps mod 2^PHASE_W
    end
  end

  // a quarter period ahead turns the sine table into cosine;
  // the table latency means it must be applied one state early
  always_comb begin
    if (state == MIX_SIN_WAIT) begin
      phase_eff = phase_reg + QUARTER_PHASE;
    end else begin
      phase_eff = phase_reg;
    end
  end

  assign lut_addr = phase_eff[PHASE_QBITS +: LUT_ABITS];  // integer part

  sine_lut u_sine_lut (
    .clk      (clk),
    .rst      (rst),
    .addr_i   (lut_addr),
    .sample_o (lut_sample)
  );

endmodule

// ==== source/mixer_pkg.sv ====
// shared definitions for the down-conversion mixer
// sample and product widths, sine table geometry,
// phase accumulator format, carrier constants and the mixer FSM states

package mixer_pkg;

  localparam int DATA_W      = 16;
  localparam int LUT_ABITS   = 8;           // 256 entries per period
  localparam int LUT_QBITS   = DATA_W - 1;  // table entries are Q1.15
  localparam int PHASE_QBITS = 4;           // fraction below table address
  localparam int PHASE_W     = LUT_ABITS + PHASE_QBITS;

  localparam logic [PHASE_W-1:0] QUARTER_PHASE = PHASE_W'(1 << (PHASE_W - 2));

  localparam int SAMP_RATE    = 48000;      // Hz
  localparam int CARRIER_FREQ = 3000;       // Hz

  // step per sample, rounded down
  localparam logic [PHASE_W-1:0] PHASE_INC = PHASE_W'(
    ((2 ** LUT_ABITS) * CARRIER_FREQ * (2 ** PHASE_QBITS)) / SAMP_RATE);

  localparam real MATH_PI = 3.14159265358979323846;

  typedef enum logic [2:0] {
    MIX_IDLE,       // waiting for a sample
    MIX_SIN_MULT,   // product with sine
    MIX_SIN_WAIT,   // sine word on the stream
    MIX_COS_MULT,   // product with cosine
    MIX_COS_WAIT    // cosine word on the stream, marked last
  } mixer_state_t;

endpackage

// ==== source/mixer_top.sv ====
// top level of the down-conversion mixer
// mixer with its sine table feeding the I/Q collector

`timescale 1ns/1ps

module mixer_top
  import mixer_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic signed [DATA_W-1:0] sample_i,
  input  logic                     sample_valid_i,
  output logic                     idle_o,
  output logic signed [DATA_W-1:0] i_o,
  output logic signed [DATA_W-1:0] q_o,
  output logic                     iq_valid_o,
  input  logic                     iq_ready_i
);

  // interleaved stream between the two blocks
  logic signed [DATA_W-1:0] mix_data;
  logic                     mix_valid;
  logic                     mix_last;
  logic                     mix_ready;

  mixer u_mixer (
    .clk            (clk),
    .rst            (rst),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .ready_i        (mix_ready),
    .idle_o         (idle_o),
    .data_o         (mix_data),
    .valid_o        (mix_valid),
    .last_o         (mix_last)
  );

  iq_collector u_iq_collector (
    .clk     (clk),
    .rst     (rst),
    .data_i  (mix_data),
    .valid_i (mix_valid),
    .last_i  (mix_last),
    .ready_o (mix_ready),
    .i_o     (i_o),
    .q_o     (q_o),
    .valid_o (iq_valid_o),
    .ready_i (iq_ready_i)
  );

endmodule

// ==== source/sine_lut.sv ====
// full-period sine table for the mixer oscillator
// entries computed at elaboration, one cycle read latency

`timescale 1ns/1ps

module sine_lut
  import mixer_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [LUT_ABITS-1:0]     addr_i,
  output logic signed [DATA_W-1:0] sample_o
);

  localparam int DEPTH = 2 ** LUT_ABITS;

  logic signed [DATA_W-1:0] table_q [DEPTH];

  // round(sin(2*pi*a/DEPTH) * full scale)
  function automatic logic signed [DATA_W-1:0] sine_entry(input int a);
    real angle;
    real scaled;
    angle  = 2.0 * MATH_PI * real'(a) / real'(DEPTH);
    scaled = $sin(angle) * real'((2 ** LUT_QBITS) - 1);
    return DATA_W'(int'(scaled));  // int cast rounds to nearest
  endfunction

  for (genvar a = 0; a < DEPTH; a++) begin : g_entry
    assign table_q[a] = sine_entry(a);
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      sample_o <= '0;
    end else begin
      sample_o <= table_q[addr_i];
    end
  end

endmodule

// ==== test/mixer_checker.sv ====
// concurrent checks on the mixer's output stream
// quiet while idle, last framing, data hold under back-pressure,
// no stream word without an accepted sample

`timescale 1ns/1ps

module mixer_checker
  import mixer_pkg::*;
(
  input logic                     clk,
  input logic                     rst,
  input mixer_state_t             state_i,
  input logic                     accept_i,
  input logic signed [DATA_W-1:0] data_i,
  input logic                     valid_i,
  input logic                     last_i,
  input logic                     ready_i
);

  a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
    (state_i == MIX_IDLE) |-> !valid_i)
    else $error("stream valid while the mixer is idle");

  a_last_framed: assert property (@(posedge clk) disable iff (rst)
    last_i |-> valid_i)
    else $error("last without valid on the stream");

  // word held until the collector takes it
  a_data_hold: assert property (@(posedge clk) disable iff (rst)
    (valid_i && !ready_i) |=> $stable(data_i))
    else $error("stream data changed during a stall");

  // sine word shows up two edges after acceptance
  a_valid_cause: assert property (@(posedge clk) disable iff (rst)
    ($rose(valid_i) && !last_i) |-> $past(accept_i, 2))
    else $error("stream word without an accepted sample");

endmodule

bind mixer mixer_checker u_checker (
  .clk      (clk),
  .rst      (rst),
  .state_i  (state),
  .accept_i (accept),
  .data_i   (data_o),
  .valid_i  (valid_o),
  .last_i   (last_o),
  .ready_i  (ready_i)
);

// ==== test/mixer_tb.sv ====
// directed testbench for the down-conversion mixer
// reference sine table and phase model, LFSR stimulus,
// stream tasks with optional output stalls, watchdog and summary

`timescale 1ns/1ps

module mixer_tb
  import mixer_pkg::*;
();

  localparam int CLK_PERIOD    = 20;
  localparam int TOTAL_SAMPLES = 75;  // 1 + 32 + 24 + 18
  localparam int MODEL_INC     =
    ((1 << LUT_ABITS) * CARRIER_FREQ * (1 << PHASE_QBITS)) / SAMP_RATE;
  localparam int MODEL_QUARTER = 1 << (PHASE_W - 2);

  logic                     clk;
  logic                     rst;
  logic signed [DATA_W-1:0] sample_i;
  logic                     sample_valid_i;
  logic                     idle_o;
  logic signed [DATA_W-1:0] i_o;
  logic signed [DATA_W-1:0] q_o;
  logic                     iq_valid_o;
  logic                     iq_ready_i;

  logic signed [DATA_W-1:0] ref_table [1 << LUT_ABITS];
  logic [PHASE_W-1:0]       model_phase;  // phase of the next queued sample
  logic [31:0]              lfsr;
  logic signed [DATA_W-1:0] src_q [$];
  logic signed [DATA_W-1:0] exp_i [$];
  logic signed [DATA_W-1:0] exp_q [$];
  int cycle_count;
  int checks;
  int errors;
  int test_checks;
  int test_errors;
  int accepted;
  int delivered;

  mixer_top dut (
    .clk            (clk),
    .rst            (rst),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .idle_o         (idle_o),
    .i_o            (i_o),
    .q_o            (q_o),
    .iq_valid_o     (iq_valid_o),
    .iq_ready_i     (iq_ready_i)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;
  always @(posedge clk) cycle_count <= cycle_count + 1;

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);  // one step per bit
    end
  endtask

  function automatic logic signed [DATA_W-1:0] ref_sine(input int a);
    real x;
    x = $sin(2.0 * 3.141592653589793 * a / 256.0) * 32767.0;
    if (x >= 0.0) begin
      return DATA_W'($rtoi($floor(x + 0.5)));
    end
    return DATA_W'(-$rtoi($floor(-x + 0.5)));  // round half away from zero
  endfunction

  function automatic logic signed [DATA_W-1:0] scaled_product(
    input logic signed [DATA_W-1:0] s, input logic signed [DATA_W-1:0] t);
    int p;
    p = int'(s) * int'(t);
    return DATA_W'(p >>> LUT_QBITS);
  endfunction

  // sample plus its expected pair at the model phase
  task automatic queue_sample(input logic signed [DATA_W-1:0] s);
    logic [PHASE_W-1:0] cos_phase;
    cos_phase = model_phase + PHASE_W'(MODEL_QUARTER);
    src_q.push_back(s);
    exp_i.push_back(scaled_product(s, ref_table[model_phase[PHASE_W-1:PHASE_QBITS]]));
    exp_q.push_back(scaled_product(s, ref_table[cos_phase[PHASE_W-1:PHASE_QBITS]]));
    model_phase = model_phase + PHASE_W'(MODEL_INC);
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    test_checks++;
    assert (expected == actual) else begin
      errors++;
      test_errors++;
      $display("MISMATCH time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    test_checks++;
    assert (cond) else begin
      errors++;
      test_errors++;
      $display("ERROR time=%0t %s", $time, what);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  // holds each sample until the mixer is idle at a rising edge
  task automatic drive_samples();
    while (src_q.size() > 0) begin
      sample_i       <= src_q.pop_front();
      sample_valid_i <= 1'b1;
      do begin
        @(negedge clk);
      end while (!idle_o);
      @(posedge clk);  // acceptance edge
      accepted++;
    end
    sample_valid_i <= 1'b0;
  endtask

  task automatic collect_pairs(input int n, input bit stall);
    logic [31:0] r;
    int got;
    got = 0;
    while (got < n) begin
      @(posedge clk);
      r = 32'd1;
      if (stall) begin
        take_bits(1, r);
      end
      iq_ready_i <= r[0];
      @(negedge clk);
      // a held pair plus a newer sample means the mixer is stalled
      if (iq_valid_o && (accepted - delivered) >= 2) begin
        expect_true(!idle_o, "idle_o went high while a pending pair held the mixer");
      end
      if (iq_valid_o && iq_ready_i) begin
        check_value("i_o", int'(exp_i.pop_front()), int'(i_o));
        check_value("q_o", int'(exp_q.pop_front()), int'(q_o));
        delivered++;
        got++;
      end
    end
    @(posedge clk);
    iq_ready_i <= 1'b1;
  endtask

  task automatic run_stream(input bit stall);
    int n;
    n = src_q.size();
    @(posedge clk);
    fork
      drive_samples();
      collect_pairs(n, stall);
    join
    @(negedge clk);
    check_value("iq_valid_o", 0, int'(iq_valid_o));  // no extra pair
    check_value("idle_o", 1, int'(idle_o));
  endtask

  task automatic reset_state();
    repeat (3) begin
      @(negedge clk);
      check_value("idle_o", 1, int'(idle_o));
      check_value("iq_valid_o", 0, int'(iq_valid_o));
    end
    @(posedge clk);
    rst <= 1'b0;  // released at the fourth edge
    @(negedge clk);
    check_value("idle_o", 1, int'(idle_o));
    check_value("iq_valid_o", 0, int'(iq_valid_o));
    report_test("reset");
  endtask

  task automatic single_sample();
    int t_acc;
    int wait_cycles;
    queue_sample(16'sd16000);
    @(posedge clk);
    sample_i       <= src_q.pop_front();
    sample_valid_i <= 1'b1;
    do begin
      @(negedge clk);
    end while (!idle_o);
    @(posedge clk);
    t_acc = cycle_count;  // count before the acceptance edge
    sample_valid_i <= 1'b0;
    do begin
      @(negedge clk);
    end while (!iq_valid_o);
    wait_cycles = cycle_count - t_acc;
    check_value("pair latency", 5, wait_cycles);
    check_value("i_o", int'(exp_i.pop_front()), int'(i_o));
    check_value("q_o", int'(exp_q.pop_front()), int'(q_o));
    @(posedge clk);
    @(negedge clk);
    check_value("iq_valid_o", 0, int'(iq_valid_o));
    report_test("single");
  endtask

  task automatic phase_progression();
    logic [31:0] r;
    for (int k = 0; k < 32; k++) begin
      take_bits(DATA_W, r);
      queue_sample(r[DATA_W-1:0]);
    end
    run_stream(1'b0);  // two full phase wraps
    report_test("phase");
  endtask

  task automatic output_backpressure();
    logic [31:0] r;
    for (int k = 0; k < 24; k++) begin
      take_bits(DATA_W, r);
      queue_sample(r[DATA_W-1:0]);
    end
    run_stream(1'b1);
    report_test("backpressure");
  endtask

  task automatic sign_extremes();
    for (int k = 0; k < 6; k++) begin
      queue_sample(16'sh8000);
      queue_sample(16'sh7fff);
      queue_sample(16'shffff);
    end
    run_stream(1'b0);
    report_test("extremes");
  endtask

  initial begin
    rst            <= 1'b1;
    sample_i       <= '0;
    sample_valid_i <= 1'b0;
    iq_ready_i     <= 1'b1;
    lfsr        = 32'hc714;
    model_phase = '0;
    checks      = 0;
    errors      = 0;
    test_checks = 0;
    test_errors = 0;
    accepted    = 0;
    delivered   = 0;
    for (int a = 0; a < (1 << LUT_ABITS); a++) begin
      ref_table[a[LUT_ABITS-1:0]] = ref_sine(a);
    end
    reset_state();
    single_sample();
    phase_progression();
    output_backpressure();
    sign_extremes();
    $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // about 5 cycles per sample without stalls, more with ready gaps
  initial begin
    #((TOTAL_SAMPLES * 40 + 200) * CLK_PERIOD);
    $display("watchdog expired at %0t with tests still running", $time);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
